// ==== compile.f ====
common/axi_pkg.sv
common/xbar_pkg.sv
xbar_arb/prio_reg.sv
xbar_arb/grant_select.sv
xbar_route/w_order_queue.sv
xbar_route/aw_router.sv
xbar_route/w_router.sv
xbar_route/b_router.sv
design/axi_write_xbar.sv
tests/axi_write_xbar_checker.sv
tests/tb_axi_write_xbar.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f \
    --top-module tb_axi_write_xbar -o tb_axi_write_xbar_sim \
    && ./obj_dir/tb_axi_write_xbar_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
    && echo "simulation run ok" && exit 0 \
    || { echo "simulation run not ok"; exit 1; }

// ==== tests/tb_axi_write_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_xbar
    import axi_pkg::*;
    import xbar_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int w_buf_depth     = 4;
    localparam int test_num        = 6;
    localparam int cycles_per_test = 200;

    typedef struct packed {
        logic [head_w-1:0] master;
        logic [id_w-1:0]   id;
        logic [1:0]        resp;
    } b_seen_t;

    logic clk = 1'b0;
    logic arst_n;
    aw_pay_t   [master_num-1:0] m_aw;
    logic      [master_num-1:0] m_awvalid;
    logic      [master_num-1:0] m_awready;
    w_pay_t    [master_num-1:0] m_w;
    logic      [master_num-1:0] m_wvalid;
    logic      [master_num-1:0] m_wready;
    b_pay_t    [master_num-1:0] m_b;
    logic      [master_num-1:0] m_bvalid;
    logic      [master_num-1:0] m_bready;
    s_aw_pay_t [slave_num-1:0]  s_aw;
    logic      [slave_num-1:0]  s_awvalid;
    logic      [slave_num-1:0]  s_awready;
    w_pay_t    [slave_num-1:0]  s_w;
    logic      [slave_num-1:0]  s_wvalid;
    logic      [slave_num-1:0]  s_wready;
    s_b_pay_t  [slave_num-1:0]  s_b = '0;
    logic      [slave_num-1:0]  s_bvalid = '0;
    logic      [slave_num-1:0]  s_bready;

    logic [31:0] lcg_state = 32'hbd0;
    int          cycle = 0;
    int          err_cnt = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    int          last_aw_master = 0;
    int          aw_order [$];
    int          aw_hs_cycle [master_num];
    int          w_last_cycle [master_num];
    b_seen_t     b_log [$];

    // slave model state, ids kept as opaque words
    logic [ext_id_w-1:0] id_buf [slave_num][16];
    int                  aw_cnt [slave_num];
    int                  w_cnt [slave_num];
    int                  b_cnt [slave_num];

    axi_write_xbar #(
        .w_buf_depth(w_buf_depth)
    ) axi_write_xbar_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .m_aw     (m_aw),
        .m_awvalid(m_awvalid),
        .m_awready(m_awready),
        .m_w      (m_w),
        .m_wvalid (m_wvalid),
        .m_wready (m_wready),
        .m_b      (m_b),
        .m_bvalid (m_bvalid),
        .m_bready (m_bready),
        .s_aw     (s_aw),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_w      (s_w),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready),
        .s_b      (s_b),
        .s_bvalid (s_bvalid),
        .s_bready (s_bready)
    );

    bind axi_write_xbar axi_write_xbar_checker axi_write_xbar_checker_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .m_aw     (m_aw),
        .m_awvalid(m_awvalid),
        .m_awready(m_awready),
        .m_wvalid (m_wvalid),
        .s_awvalid(s_awvalid),
        .s_wvalid (s_wvalid)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // each slave answers with its own fixed response code
    function automatic logic [1:0] model_resp(input int s);
        return 2'(s + 1);
    endfunction

    function automatic aw_pay_t make_aw(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                                        input logic [7:0] len);
        aw_pay_t pay;
        pay.id    = id;
        pay.addr  = addr;
        pay.len   = len;
        pay.size  = 3'd2;
        pay.burst = 2'b01;
        return pay;
    endfunction

    // slaves accept every AW and W and answer one B per burst in AW order
    always @(posedge clk or negedge arst_n) begin
        int nw;
        int nb;
        if (!arst_n) begin
            s_bvalid <= '0;
            s_b      <= '0;
            for (int s = 0; s < slave_num; s++) begin
                aw_cnt[s] <= 0;
                w_cnt[s]  <= 0;
                b_cnt[s]  <= 0;
            end
        end else begin
            for (int s = 0; s < slave_num; s++) begin
                nw = w_cnt[s] + ((s_wvalid[s] && s_wready[s] && s_w[s].last) ? 1 : 0);
                nb = b_cnt[s] + ((s_bvalid[s] && s_bready[s]) ? 1 : 0);
                if (s_awvalid[s] && s_awready[s]) begin
                    id_buf[s][aw_cnt[s] % 16] <= s_aw[s].id.raw;
                    aw_cnt[s] <= aw_cnt[s] + 1;
                end
                w_cnt[s]       <= nw;
                b_cnt[s]       <= nb;
                s_bvalid[s]    <= (nb < nw);
                s_b[s].id.raw  <= id_buf[s][nb % 16];
                s_b[s].resp    <= model_resp(s);
            end
        end
    end

    always @(posedge clk) begin
        b_seen_t e;
        for (int m = 0; m < master_num; m++) begin
            if (m_bvalid[m] && m_bready[m]) begin
                e.master = head_w'(m);
                e.id     = m_b[m].id;
                e.resp   = m_b[m].resp;
                b_log.push_back(e);
            end
        end
    end

    task automatic send_aw(input int m, input logic [addr_w-1:0] addr, input logic [id_w-1:0] id,
                           input logic [7:0] len, input int sl);
        s_aw_pay_t exp;
        exp.id.f.head = head_w'(m);
        exp.id.f.id   = id;
        exp.addr      = addr;
        exp.len       = len;
        exp.size      = 3'd2;
        exp.burst     = 2'b01;
        @(posedge clk);
        m_aw[m]      <= make_aw(id, addr, len);
        m_awvalid[m] <= 1'b1;
        do begin
            @(posedge clk);
        end while (!m_awready[m]);
        if (!s_awvalid[sl]) begin
            $display("ERR s_awvalid[%0d] got %h exp %h", sl, s_awvalid[sl], 1'b1);
            err_cnt++;
        end
        if (s_aw[sl] != exp) begin
            $display("ERR s_aw[%0d] got %h exp %h", sl, s_aw[sl], exp);
            err_cnt++;
        end
        aw_order.push_back(m);
        aw_hs_cycle[m] = cycle;
        last_aw_master = m;
        m_awvalid[m] <= 1'b0;
    endtask

    task automatic send_w(input int m, input int beats, input int sl);
        w_pay_t pay;
        @(posedge clk);
        for (int b = 0; b < beats; b++) begin
            pay.data = lcg_next();
            pay.strb = '1;
            pay.last = (b == beats - 1);
            m_w[m]      <= pay;
            m_wvalid[m] <= 1'b1;
            do begin
                @(posedge clk);
            end while (!m_wready[m]);
            if (!s_wvalid[sl]) begin
                $display("ERR s_wvalid[%0d] got %h exp %h", sl, s_wvalid[sl], 1'b1);
                err_cnt++;
            end
            if (s_w[sl] != pay) begin
                $display("ERR s_w[%0d] got %h exp %h", sl, s_w[sl], pay);
                err_cnt++;
            end
        end
        m_wvalid[m] <= 1'b0;
        w_last_cycle[m] = cycle;
    endtask

    task automatic expect_b(input int m, input logic [id_w-1:0] id, input logic [1:0] resp);
        int idx;
        idx = -1;
        while (idx < 0) begin
            @(negedge clk);
            for (int i = 0; i < b_log.size(); i++) begin
                if (idx < 0 && b_log[i].master == head_w'(m)) begin
                    idx = i;
                end
            end
        end
        if (b_log[idx].id != id) begin
            $display("ERR m_b[%0d].id got %h exp %h", m, b_log[idx].id, id);
            err_cnt++;
        end
        if (b_log[idx].resp != resp) begin
            $display("ERR m_b[%0d].resp got %h exp %h", m, b_log[idx].resp, resp);
            err_cnt++;
        end
        b_log.delete(idx);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_quiet();
        int errs;
        errs = err_cnt;
        repeat (5) begin
            @(posedge clk);
            if (s_awvalid != '0 || s_wvalid != '0) begin
                $display("ERR s_awvalid/s_wvalid got %h/%h exp 0/0", s_awvalid, s_wvalid);
                err_cnt++;
            end
            if (m_awready != '0 || m_wready != '0) begin
                $display("ERR m_awready/m_wready got %h/%h exp 0/0", m_awready, m_wready);
                err_cnt++;
            end
        end
        report_test("quiet after reset", errs);
    endtask

    task automatic test_single();
        int errs;
        errs = err_cnt;
        fork
            send_aw(1, 32'h1000_0040, 4'h5, 8'd1, 1);
            send_w(1, 2, 1);
        join
        expect_b(1, 4'h5, model_resp(1));
        report_test("single write routing", errs);
    endtask

    task automatic test_contention();
        int          errs;
        int          first;
        logic [31:0] rnd;
        logic [3:0]  id0;
        logic [3:0]  id1;
        errs = err_cnt;
        for (int r = 0; r < 2; r++) begin
            rnd = lcg_next();
            id0 = rnd[3:0];
            id1 = rnd[7:4];
            // least recently served master goes first
            first = 1 - last_aw_master;
            aw_order.delete();
            fork
                send_aw(0, 32'h0000_0200, id0, 8'd0, 0);
                send_aw(1, 32'h0000_0300, id1, 8'd0, 0);
            join
            if (aw_order[0] != first) begin
                $display("round %0d: slave 0 served master %0d first instead of master %0d",
                         r, aw_order[0], first);
                err_cnt++;
            end
            send_w(first, 1, 0);
            send_w(1 - first, 1, 0);
            expect_b(0, id0, model_resp(0));
            expect_b(1, id1, model_resp(0));
        end
        report_test("contention order", errs);
    endtask

    task automatic test_parallel();
        int          errs;
        logic [31:0] rnd;
        errs = err_cnt;
        rnd = lcg_next();
        fork
            send_aw(0, 32'h0000_0100, rnd[3:0], 8'd0, 0);
            send_aw(1, 32'h1000_0200, rnd[7:4], 8'd0, 1);
        join
        if (aw_hs_cycle[0] != aw_hs_cycle[1]) begin
            $display("writes to different slaves were not accepted in the same cycle");
            err_cnt++;
        end
        fork
            send_w(0, 1, 0);
            send_w(1, 1, 1);
        join
        expect_b(0, rnd[3:0], model_resp(0));
        expect_b(1, rnd[7:4], model_resp(1));
        report_test("parallel writes", errs);
    endtask

    task automatic test_unmapped();
        int errs;
        errs = err_cnt;
        @(posedge clk);
        m_aw[0]      <= make_aw(4'h2, 32'h2000_0000, 8'd0);
        m_awvalid[0] <= 1'b1;
        repeat (50) begin
            @(posedge clk);
            if (m_awready[0] || s_awvalid != '0) begin
                $display("ERR m_awready[0]/s_awvalid got %h/%h exp 0/0", m_awready[0], s_awvalid);
                err_cnt++;
            end
        end
        m_awvalid[0] <= 1'b0;
        report_test("unmapped address", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = err_cnt;
        for (int i = 0; i < w_buf_depth; i++) begin
            send_aw(0, 32'h0000_1000 + 32'(i * 16), 4'(i), 8'd0, 0);
        end
        fork
            send_aw(0, 32'h0000_2000, 4'(w_buf_depth), 8'd0, 0);
            begin
                repeat (10) begin
                    @(posedge clk);
                    if (m_awready[0]) begin
                        $display("ERR m_awready[0] got %h exp %h", m_awready[0], 1'b0);
                        err_cnt++;
                    end
                end
                send_w(0, 1, 0);
            end
        join
        if (aw_hs_cycle[0] <= w_last_cycle[0]) begin
            $display("AW was accepted before the W order queue had room");
            err_cnt++;
        end
        for (int i = 0; i < w_buf_depth; i++) begin
            send_w(0, 1, 0);
        end
        for (int i = 0; i <= w_buf_depth; i++) begin
            expect_b(0, 4'(i), model_resp(0));
        end
        report_test("back-pressure", errs);
    endtask

    initial begin
        #(clk_period * (10 + test_num * cycles_per_test));
        $display("watchdog: run did not end within %0d cycles",
                 10 + test_num * cycles_per_test);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        m_aw      = '0;
        m_awvalid = '0;
        m_w       = '0;
        m_wvalid  = '0;
        m_bready  = '1;
        s_awready = '1;
        s_wready  = '1;
        arst_n    = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        test_quiet();
        test_single();
        test_contention();
        test_parallel();
        test_unmapped();
        test_backpressure();
        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/axi_write_xbar_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_xbar_checker
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input logic                       clk,
    input logic                       arst_n,
    input aw_pay_t [master_num-1:0]   m_aw,
    input logic    [master_num-1:0]   m_awvalid,
    input logic    [master_num-1:0]   m_awready,
    input logic    [master_num-1:0]   m_wvalid,
    input logic    [slave_num-1:0]    s_awvalid,
    input logic    [slave_num-1:0]    s_wvalid
);

    for (genvar m = 0; m < master_num; m++) begin : g_master
        assert property (@(posedge clk) disable iff (!arst_n)
            $rose(m_awready[m]) |-> m_awvalid[m])
            else $error("m_awready[%0d] rose without m_awvalid", m);
    end

    // two masters granted the same slave in one cycle
    for (genvar s = 0; s < slave_num; s++) begin : g_slave
        logic both_won;
        assign both_won = m_awready[0] && m_awready[1]
            && ((m_aw[0].addr & slave_mask[s]) == slave_base[s])
            && ((m_aw[1].addr & slave_mask[s]) == slave_base[s]);
        assert property (@(posedge clk) disable iff (!arst_n) !(s_awvalid[s] && both_won))
            else $error("slave %0d accepted two AWs in one cycle", s);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        (m_awvalid == '0 && m_wvalid == '0) |-> (s_awvalid == '0 && s_wvalid == '0))
        else $error("slave side valid high while master inputs are quiet");

endmodule

`default_nettype wire

// ==== design/axi_write_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_xbar
    import axi_pkg::*;
    import xbar_pkg::*;
#(
    parameter int w_buf_depth = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  aw_pay_t   [master_num-1:0]   m_aw,
    input  logic      [master_num-1:0]   m_awvalid,
    output logic      [master_num-1:0]   m_awready,
    input  w_pay_t    [master_num-1:0]   m_w,
    input  logic      [master_num-1:0]   m_wvalid,
    output logic      [master_num-1:0]   m_wready,
    output b_pay_t    [master_num-1:0]   m_b,
    output logic      [master_num-1:0]   m_bvalid,
    input  logic      [master_num-1:0]   m_bready,
    output s_aw_pay_t [slave_num-1:0]    s_aw,
    output logic      [slave_num-1:0]    s_awvalid,
    input  logic      [slave_num-1:0]    s_awready,
    output w_pay_t    [slave_num-1:0]    s_w,
    output logic      [slave_num-1:0]    s_wvalid,
    input  logic      [slave_num-1:0]    s_wready,
    input  s_b_pay_t  [slave_num-1:0]    s_b,
    input  logic      [slave_num-1:0]    s_bvalid,
    output logic      [slave_num-1:0]    s_bready
);

    // AW acceptance feeds the W order queues
    logic       [master_num-1:0] q_enq;
    slave_sel_t [master_num-1:0] q_enq_sel;
    logic       [master_num-1:0] q_full;

    aw_router #(
        .w_buf_depth(w_buf_depth)
    ) aw_router_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .m_aw     (m_aw),
        .m_awvalid(m_awvalid),
        .m_awready(m_awready),
        .s_aw     (s_aw),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .q_full   (q_full),
        .q_enq    (q_enq),
        .q_enq_sel(q_enq_sel)
    );

    w_router #(
        .w_buf_depth(w_buf_depth)
    ) w_router_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .m_w      (m_w),
        .m_wvalid (m_wvalid),
        .m_wready (m_wready),
        .s_w      (s_w),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready),
        .q_enq    (q_enq),
        .q_enq_sel(q_enq_sel),
        .q_full   (q_full)
    );

    b_router b_router_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_b     (s_b),
        .s_bvalid(s_bvalid),
        .s_bready(s_bready),
        .m_b     (m_b),
        .m_bvalid(m_bvalid),
        .m_bready(m_bready)
    );

endmodule

`default_nettype wire

// ==== xbar_route/b_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module b_router
    import axi_pkg::*;
    import xbar_pkg::*;
(
    input  logic                           clk,
    input  logic                           arst_n,
    input  s_b_pay_t    [slave_num-1:0]    s_b,
    input  logic        [slave_num-1:0]    s_bvalid,
    output logic        [slave_num-1:0]    s_bready,
    output b_pay_t      [master_num-1:0]   m_b,
    output logic        [master_num-1:0]   m_bvalid,
    input  logic        [master_num-1:0]   m_bready
);

    master_sel_t [slave_num-1:0]                  b_req;
    master_sel_t [slave_num-1:0]                  b_grant;
    logic        [slave_num-1:0][slave_num-1:0]   b_prio;
    logic        [slave_num-1:0]                  b_hs;

    always_comb begin
        for (int s = 0; s < slave_num; s++) begin
            // target master comes from the id head
            b_req[s]    = s_bvalid[s] ? master_sel_t'(master_sel_t'(1) << s_b[s].id.f.head) : '0;
            s_bready[s] = |(b_grant[s] & m_bready);
            b_hs[s]     = s_bvalid[s] && s_bready[s];
        end
    end

    always_comb begin
        for (int m = 0; m < master_num; m++) begin
            m_b[m]      = '0;
            m_bvalid[m] = 1'b0;
            for (int s = 0; s < slave_num; s++) begin
                if (b_grant[s][m]) begin
                    m_b[m].id   = s_b[s].id.f.id;
                    m_b[m].resp = s_b[s].resp;
                    m_bvalid[m] = 1'b1;
                end
            end
        end
    end

    prio_reg #(
        .sender_num(slave_num)
    ) b_prio_reg (
        .clk   (clk),
        .arst_n(arst_n),
        .hs    (b_hs),
        .prio  (b_prio)
    );

    grant_select #(
        .sender_num  (slave_num),
        .receiver_num(master_num)
    ) b_grant_select (
        .req  (b_req),
        .prio (b_prio),
        .grant(b_grant)
    );

endmodule

`default_nettype wire

// ==== xbar_route/w_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module w_router
    import axi_pkg::*;
    import xbar_pkg::*;
#(
    parameter int w_buf_depth = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  w_pay_t     [master_num-1:0]   m_w,
    input  logic       [master_num-1:0]   m_wvalid,
    output logic       [master_num-1:0]   m_wready,
    output w_pay_t     [slave_num-1:0]    s_w,
    output logic       [slave_num-1:0]    s_wvalid,
    input  logic       [slave_num-1:0]    s_wready,
    input  logic       [master_num-1:0]   q_enq,
    input  slave_sel_t [master_num-1:0]   q_enq_sel,
    output logic       [master_num-1:0]   q_full
);

    slave_sel_t [master_num-1:0]                   head_sel;
    logic       [master_num-1:0]                   q_empty;
    logic       [master_num-1:0]                   w_done;
    slave_sel_t [master_num-1:0]                   w_req;
    slave_sel_t [master_num-1:0]                   w_grant;
    logic       [master_num-1:0][master_num-1:0]   w_prio;

    for (genvar m = 0; m < master_num; m++) begin : g_queue
        w_order_queue #(
            .w_buf_depth(w_buf_depth)
        ) w_order_queue_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .enq     (q_enq[m]),
            .enq_sel (q_enq_sel[m]),
            .deq     (w_done[m]),
            .head_sel(head_sel[m]),
            .empty   (q_empty[m]),
            .full    (q_full[m])
        );
    end

    always_comb begin
        for (int m = 0; m < master_num; m++) begin
            // head of the queue is the slave of the oldest open burst
            w_req[m]    = q_empty[m] ? '0 : head_sel[m];
            m_wready[m] = |(w_grant[m] & s_wready);
            w_done[m]   = m_wvalid[m] && m_wready[m] && m_w[m].last;
        end
    end

    always_comb begin
        for (int s = 0; s < slave_num; s++) begin
            s_w[s]      = '0;
            s_wvalid[s] = 1'b0;
            for (int m = 0; m < master_num; m++) begin
                if (w_grant[m][s]) begin
                    s_w[s]      = m_w[m];
                    s_wvalid[s] = m_wvalid[m];
                end
            end
        end
    end

    // order only moves at burst end so bursts never interleave
    prio_reg #(
        .sender_num(master_num)
    ) w_prio_reg (
        .clk   (clk),
        .arst_n(arst_n),
        .hs    (w_done),
        .prio  (w_prio)
    );

    grant_select #(
        .sender_num  (master_num),
        .receiver_num(slave_num)
    ) w_grant_select (
        .req  (w_req),
        .prio (w_prio),
        .grant(w_grant)
    );

endmodule

`default_nettype wire

// ==== xbar_route/aw_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module aw_router
    import axi_pkg::*;
    import xbar_pkg::*;
#(
    parameter int w_buf_depth = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  aw_pay_t    [master_num-1:0]   m_aw,
    input  logic       [master_num-1:0]   m_awvalid,
    output logic       [master_num-1:0]   m_awready,
    output s_aw_pay_t  [slave_num-1:0]    s_aw,
    output logic       [slave_num-1:0]    s_awvalid,
    input  logic       [slave_num-1:0]    s_awready,
    input  logic       [master_num-1:0]   q_full,
    output logic       [master_num-1:0]   q_enq,
    output slave_sel_t [master_num-1:0]   q_enq_sel
);

    slave_sel_t [master_num-1:0]                   aw_req;
    slave_sel_t [master_num-1:0]                   aw_grant;
    logic       [master_num-1:0][master_num-1:0]   aw_prio;
    s_aw_pay_t  [master_num-1:0]                   ext_aw;

    // a zero deep queue could never take an AW
    if (w_buf_depth < 1) begin : g_depth_check
        $error("aw_router: w_buf_depth must be at least 1");
    end

    always_comb begin
        for (int m = 0; m < master_num; m++) begin
            // no request while the W order queue has no room
            aw_req[m] = (m_awvalid[m] && !q_full[m]) ? decode_addr(m_aw[m].addr) : '0;

            ext_aw[m].id.f.head = head_w'(m);
            ext_aw[m].id.f.id   = m_aw[m].id;
            ext_aw[m].addr      = m_aw[m].addr;
            ext_aw[m].len       = m_aw[m].len;
            ext_aw[m].size      = m_aw[m].size;
            ext_aw[m].burst     = m_aw[m].burst;

            m_awready[m] = |(aw_grant[m] & s_awready);
            q_enq[m]     = m_awvalid[m] && m_awready[m];
            q_enq_sel[m] = aw_req[m];
        end
    end

    always_comb begin
        for (int s = 0; s < slave_num; s++) begin
            s_aw[s]      = '0;
            s_awvalid[s] = 1'b0;
            for (int m = 0; m < master_num; m++) begin
                if (aw_grant[m][s]) begin
                    s_aw[s]      = ext_aw[m];
                    s_awvalid[s] = 1'b1;
                end
            end
        end
    end

    prio_reg #(
        .sender_num(master_num)
    ) aw_prio_reg (
        .clk   (clk),
        .arst_n(arst_n),
        .hs    (q_enq),
        .prio  (aw_prio)
    );

    grant_select #(
        .sender_num  (master_num),
        .receiver_num(slave_num)
    ) aw_grant_select (
        .req  (aw_req),
        .prio (aw_prio),
        .grant(aw_grant)
    );

endmodule

`default_nettype wire

// ==== xbar_route/w_order_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module w_order_queue
    import xbar_pkg::*;
#(
    parameter int w_buf_depth = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       enq,
    input  slave_sel_t enq_sel,
    input  logic       deq,
    output slave_sel_t head_sel,
    output logic       empty,
    output logic       full
);

    localparam int ptr_w = (w_buf_depth > 1) ? $clog2(w_buf_depth) : 1;
    localparam int cnt_w = $clog2(w_buf_depth + 1);

    slave_sel_t       mem [w_buf_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_enq;
    logic             do_deq;

    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(w_buf_depth));
    assign head_sel = mem[rd_ptr];

    assign do_enq = enq && !full;
    assign do_deq = deq && !empty;

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_sel;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= (wr_ptr == ptr_w'(w_buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == ptr_w'(w_buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // both at once leaves the count alone
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== xbar_arb/grant_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module grant_select #(
    parameter int sender_num   = 2,
    parameter int receiver_num = 2
) (
    input  logic [sender_num-1:0][receiver_num-1:0] req,
    input  logic [sender_num-1:0][sender_num-1:0]   prio,
    output logic [sender_num-1:0][receiver_num-1:0] grant
);

    // a request passes unless another requester of the same receiver ranks higher
    always_comb begin
        for (int i = 0; i < sender_num; i++) begin
            for (int r = 0; r < receiver_num; r++) begin
                grant[i][r] = req[i][r];
                for (int j = 0; j < sender_num; j++) begin
                    if (j != i && req[j][r] && prio[j][i]) begin
                        grant[i][r] = 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== xbar_arb/prio_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module prio_reg #(
    parameter int sender_num = 2
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [sender_num-1:0]                hs,
    output logic [sender_num-1:0][sender_num-1:0] prio
);

    // prio[i][j] set means sender i outranks sender j
    logic [sender_num-1:0][sender_num-1:0] prio_d;

    always_comb begin
        for (int i = 0; i < sender_num; i++) begin
            for (int j = 0; j < sender_num; j++) begin
                if (i == j) begin
                    prio_d[i][j] = 1'b0;
                end else if (hs[i] && !hs[j]) begin
                    // served sender drops below the idle one
                    prio_d[i][j] = 1'b0;
                end else if (hs[j] && !hs[i]) begin
                    prio_d[i][j] = 1'b1;
                end else begin
                    prio_d[i][j] = prio[i][j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < sender_num; i++) begin
                for (int j = 0; j < sender_num; j++) begin
                    prio[i][j] <= (i < j);
                end
            end
        end else begin
            prio <= prio_d;
        end
    end

endmodule

`default_nettype wire

// ==== common/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

    import axi_pkg::*;

    localparam int master_num = 2;
    localparam int slave_num  = 2;
    localparam int head_w     = (master_num > 1) ? $clog2(master_num) : 1;
    localparam int ext_id_w   = head_w + id_w;

    // index 0 is the rightmost entry
    localparam logic [slave_num-1:0][addr_w-1:0] slave_base = {32'h1000_0000, 32'h0000_0000};
    localparam logic [slave_num-1:0][addr_w-1:0] slave_mask = {32'hF000_0000, 32'hF000_0000};

    typedef logic [slave_num-1:0]  slave_sel_t;
    typedef logic [master_num-1:0] master_sel_t;

    typedef struct packed {
        logic [head_w-1:0] head;
        logic [id_w-1:0]   id;
    } ext_id_s_t;

    // slaves treat the id as opaque, the B path splits off the head
    typedef union packed {
        logic [ext_id_w-1:0] raw;
        ext_id_s_t           f;
    } ext_id_u;

    typedef struct packed {
        ext_id_u           id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } s_aw_pay_t;

    typedef struct packed {
        ext_id_u    id;
        logic [1:0] resp;
    } s_b_pay_t;

    function automatic slave_sel_t decode_addr(input logic [addr_w-1:0] addr);
        slave_sel_t sel;
        sel = '0;
        for (int s = 0; s < slave_num; s++) begin
            if ((addr & slave_mask[s]) == slave_base[s]) begin
                sel[s] = 1'b1;
            end
        end
        return sel;
    endfunction

endpackage

`default_nettype wire

// ==== common/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int strb_w = data_w / 8;

    // master side AW, lock/cache/prot not carried
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } aw_pay_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_pay_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_pay_t;

endpackage

`default_nettype wire
